//--- hdl/mem_pipe_config.svh
// ====================
// Sizing of the memory pipeline and its data banks
// Included by the package and by every RTL module that needs a size
// ====================
`ifndef MEM_PIPE_CONFIG_SVH
`define MEM_PIPE_CONFIG_SVH

// Doubleword width
`define MEM_DATA_W 64

// Number of doubleword-interleaved banks, 2, 4 or 8
`define MEM_NUM_BANKS 4

// Doublewords in one bank
`define MEM_BANK_DEPTH 64

// Width of the effective address carried through the pipe
`define MEM_ADDR_W 16

// Bytes of data memory, addresses at or above this fault
`define MEM_BYTES (`MEM_NUM_BANKS * `MEM_BANK_DEPTH * 8)

`endif

//--- hdl/mem_pipe_pkg.sv
// ====================
// Types shared by the memory pipeline modules
// Referenced by scoped name only
// ====================
`include "mem_pipe_config.svh"

package mem_pipe_pkg;

  // Load and store operations
  typedef enum logic [3:0] {
    e_lb  = 4'd0,
    e_lh  = 4'd1,
    e_lw  = 4'd2,
    e_ld  = 4'd3,
    e_lbu = 4'd4,
    e_lhu = 4'd5,
    e_lwu = 4'd6,
    e_sb  = 4'd7,
    e_sh  = 4'd8,
    e_sw  = 4'd9,
    e_sd  = 4'd10
  } mem_op_e;

  // Effective address inside the data memory
  typedef logic [`MEM_ADDR_W-1:0] addr_t;

  typedef logic [`MEM_DATA_W-1:0] dword_t;

  // One enable per byte of a doubleword
  typedef logic [`MEM_DATA_W/8-1:0] bmask_t;

  typedef logic [4:0] reg_idx_t;

  // Bank number and row inside a bank
  typedef logic [$clog2(`MEM_NUM_BANKS)-1:0] bank_sel_t;
  typedef logic [$clog2(`MEM_BANK_DEPTH)-1:0] bank_idx_t;

endpackage

//--- hdl/mem_agen.sv
// ====================
// Address stage: effective address, alignment and range checks,
// bank strobes, store lane data and the registered load descriptor
// ====================
`timescale 1ns/1ps
`include "mem_pipe_config.svh"

module mem_agen
  (input  logic                        clk_i
   , input  logic                      rst_n_i
   , input  logic                      flush_i
   , input  logic                      req_v_i
   , input  mem_pipe_pkg::mem_op_e     req_op_i
   , input  mem_pipe_pkg::dword_t      rs1_i
   , input  mem_pipe_pkg::dword_t      imm_i
   , input  mem_pipe_pkg::dword_t      rs2_i
   , input  mem_pipe_pkg::reg_idx_t    rd_i
   , input  logic                      early_i

   , output logic [`MEM_NUM_BANKS-1:0] bank_en_o
   , output logic                      bank_we_o
   , output mem_pipe_pkg::bank_idx_t   bank_idx_o
   , output mem_pipe_pkg::dword_t      bank_wdata_o
   , output mem_pipe_pkg::bmask_t      bank_wmask_o

   , output logic                      ld_v_o
   , output mem_pipe_pkg::mem_op_e     ld_op_o
   , output mem_pipe_pkg::bank_sel_t   ld_bank_o
   , output logic [2:0]                ld_byte_o
   , output logic                      ld_early_o
   , output mem_pipe_pkg::reg_idx_t    ld_rd_o

   , output logic                      load_misaligned_o
   , output logic                      store_misaligned_o
   , output logic                      load_access_fault_o
   , output logic                      store_access_fault_o
   );

  localparam int sel_width_lp = $bits(mem_pipe_pkg::bank_sel_t);
  localparam int idx_width_lp = $bits(mem_pipe_pkg::bank_idx_t);

  mem_pipe_pkg::dword_t    eaddr;
  mem_pipe_pkg::addr_t     addr;
  mem_pipe_pkg::bank_sel_t bank;
  mem_pipe_pkg::bank_idx_t row;
  mem_pipe_pkg::bmask_t    base_mask;
  logic [1:0]              size;
  logic                    is_load;
  logic                    misaligned;
  logic                    out_of_range;
  logic                    good;

  assign eaddr = rs1_i + imm_i;
  assign addr  = eaddr[`MEM_ADDR_W-1:0];
  // Doubleword interleave, low dword bits pick the bank
  assign bank  = addr[3 +: sel_width_lp];
  assign row   = addr[3 + sel_width_lp +: idx_width_lp];

  always_comb begin
    is_load = 1'b1;
    size    = 2'd3;
    case (req_op_i)
      mem_pipe_pkg::e_lb, mem_pipe_pkg::e_lbu: size = 2'd0;
      mem_pipe_pkg::e_lh, mem_pipe_pkg::e_lhu: size = 2'd1;
      mem_pipe_pkg::e_lw, mem_pipe_pkg::e_lwu: size = 2'd2;
      mem_pipe_pkg::e_sb: begin is_load = 1'b0; size = 2'd0; end
      mem_pipe_pkg::e_sh: begin is_load = 1'b0; size = 2'd1; end
      mem_pipe_pkg::e_sw: begin is_load = 1'b0; size = 2'd2; end
      mem_pipe_pkg::e_sd: is_load = 1'b0;
      default: size = 2'd3;
    endcase
  end

  always_comb begin
    case (size)
      2'd1:    misaligned = addr[0];
      2'd2:    misaligned = |addr[1:0];
      2'd3:    misaligned = |addr[2:0];
      default: misaligned = 1'b0;
    endcase
    case (size)
      2'd0:    base_mask = 8'h01;
      2'd1:    base_mask = 8'h03;
      2'd2:    base_mask = 8'h0f;
      default: base_mask = 8'hff;
    endcase
  end

  // Full 64-bit sum so wrapped or huge addresses still fault
  assign out_of_range = (eaddr >= mem_pipe_pkg::dword_t'(`MEM_BYTES));
  assign good         = req_v_i & ~misaligned & ~out_of_range;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bank_en_o            <= '0;
      bank_we_o            <= 1'b0;
      ld_v_o               <= 1'b0;
      load_misaligned_o    <= 1'b0;
      store_misaligned_o   <= 1'b0;
      load_access_fault_o  <= 1'b0;
      store_access_fault_o <= 1'b0;
    end else if (flush_i) begin
      bank_en_o            <= '0;
      bank_we_o            <= 1'b0;
      ld_v_o               <= 1'b0;
      load_misaligned_o    <= 1'b0;
      store_misaligned_o   <= 1'b0;
      load_access_fault_o  <= 1'b0;
      store_access_fault_o <= 1'b0;
    end else begin
      bank_en_o            <= good ? (`MEM_NUM_BANKS'(1) << bank) : '0;
      bank_we_o            <= good & ~is_load;
      ld_v_o               <= good & is_load;
      load_misaligned_o    <= req_v_i & is_load & misaligned;
      store_misaligned_o   <= req_v_i & ~is_load & misaligned;
      // Misalignment takes priority over the access fault
      load_access_fault_o  <= req_v_i & is_load & ~misaligned & out_of_range;
      store_access_fault_o <= req_v_i & ~is_load & ~misaligned & out_of_range;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_v_i) begin
      bank_idx_o   <= row;
      bank_wdata_o <= rs2_i << {addr[2:0], 3'b000};
      bank_wmask_o <= base_mask << addr[2:0];
      ld_op_o      <= req_op_i;
      ld_bank_o    <= bank;
      ld_byte_o    <= addr[2:0];
      ld_early_o   <= early_i;
      ld_rd_o      <= rd_i;
    end
  end

endmodule

//--- hdl/mem_bank.sv
// ====================
// One doubleword-wide data bank, byte write enables, registered read
// ====================
`timescale 1ns/1ps
`include "mem_pipe_config.svh"

module mem_bank
  (input  logic                      clk_i
   , input  logic                    en_i
   , input  logic                    we_i
   , input  mem_pipe_pkg::bank_idx_t idx_i
   , input  mem_pipe_pkg::dword_t    wdata_i
   , input  mem_pipe_pkg::bmask_t    wmask_i
   , output mem_pipe_pkg::dword_t    rdata_o
   );

  localparam int bytes_lp = $bits(mem_pipe_pkg::bmask_t);

  mem_pipe_pkg::dword_t mem [`MEM_BANK_DEPTH];

  // Masked byte write
  always_ff @(posedge clk_i) begin
    if (en_i && we_i) begin
      for (int b = 0; b < bytes_lp; b++) begin
        if (wmask_i[b]) begin
          mem[idx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Read port holds its value until the next enabled read
  always_ff @(posedge clk_i) begin
    if (en_i && !we_i) begin
      rdata_o <= mem[idx_i];
    end
  end

endmodule

//--- hdl/mem_align.sv
// ====================
// Load stage: selects the bank word, extracts and extends the bytes,
// drives the early port at E+2 and the final port at E+3
// ====================
`timescale 1ns/1ps
`include "mem_pipe_config.svh"

module mem_align
  (input  logic                                      clk_i
   , input  logic                                    rst_n_i
   , input  logic                                    flush_i
   , input  logic                                    ld_v_i
   , input  mem_pipe_pkg::mem_op_e                   ld_op_i
   , input  mem_pipe_pkg::bank_sel_t                 ld_bank_i
   , input  logic [2:0]                              ld_byte_i
   , input  logic                                    ld_early_i
   , input  mem_pipe_pkg::reg_idx_t                  ld_rd_i
   , input  logic [`MEM_NUM_BANKS*`MEM_DATA_W-1:0]   bank_rdata_i

   , output logic                                    early_v_o
   , output mem_pipe_pkg::dword_t                    early_data_o
   , output logic                                    final_v_o
   , output mem_pipe_pkg::dword_t                    final_data_o
   , output mem_pipe_pkg::reg_idx_t                  rd_o
   );

  // Descriptor aligned with the bank read
  logic                    s1_v;
  logic                    s1_early;
  mem_pipe_pkg::mem_op_e   s1_op;
  mem_pipe_pkg::bank_sel_t s1_bank;
  logic [2:0]              s1_byte;
  mem_pipe_pkg::reg_idx_t  s1_rd;

  mem_pipe_pkg::dword_t    sel_dw;
  mem_pipe_pkg::dword_t    shifted;
  mem_pipe_pkg::dword_t    ext;

  logic                    r2_v;
  logic                    r2_early;
  mem_pipe_pkg::dword_t    r2_data;
  mem_pipe_pkg::reg_idx_t  r2_rd;

  logic                    fin_v;
  mem_pipe_pkg::dword_t    fin_data;
  mem_pipe_pkg::reg_idx_t  fin_rd;

  assign sel_dw  = bank_rdata_i[s1_bank*`MEM_DATA_W +: `MEM_DATA_W];
  assign shifted = sel_dw >> {s1_byte, 3'b000};

  always_comb begin
    case (s1_op)
      mem_pipe_pkg::e_lb:  ext = {{56{shifted[7]}}, shifted[7:0]};
      mem_pipe_pkg::e_lh:  ext = {{48{shifted[15]}}, shifted[15:0]};
      mem_pipe_pkg::e_lw:  ext = {{32{shifted[31]}}, shifted[31:0]};
      mem_pipe_pkg::e_lbu: ext = {56'd0, shifted[7:0]};
      mem_pipe_pkg::e_lhu: ext = {48'd0, shifted[15:0]};
      mem_pipe_pkg::e_lwu: ext = {32'd0, shifted[31:0]};
      default:             ext = shifted;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_v  <= 1'b0;
      r2_v  <= 1'b0;
      fin_v <= 1'b0;
    end else if (flush_i) begin
      s1_v  <= 1'b0;
      r2_v  <= 1'b0;
      fin_v <= 1'b0;
    end else begin
      s1_v  <= ld_v_i;
      r2_v  <= s1_v;
      fin_v <= r2_v & ~r2_early;
    end
  end

  always_ff @(posedge clk_i) begin
    s1_op    <= ld_op_i;
    s1_bank  <= ld_bank_i;
    s1_byte  <= ld_byte_i;
    s1_early <= ld_early_i;
    s1_rd    <= ld_rd_i;
    if (s1_v) begin
      r2_data  <= ext;
      r2_early <= s1_early;
      r2_rd    <= s1_rd;
    end
    // One-deep final register
    if (r2_v && !r2_early) begin
      fin_data <= r2_data;
      fin_rd   <= r2_rd;
    end
  end

  assign early_v_o    = r2_v & r2_early;
  assign early_data_o = r2_data;
  assign final_v_o    = fin_v;
  assign final_data_o = fin_data;
  // Older request wins when both ports fire in one cycle
  assign rd_o         = fin_v ? fin_rd : r2_rd;

endmodule

//--- hdl/mem_pipe_top.sv
// ====================
// Memory pipeline top: address stage, interleaved banks, load aligner
// ====================
`timescale 1ns/1ps
`include "mem_pipe_config.svh"

module mem_pipe_top
  (input  logic                     clk_i
   , input  logic                   rst_n_i
   , input  logic                   flush_i

   , input  logic                   req_v_i
   , input  mem_pipe_pkg::mem_op_e  req_op_i
   , input  mem_pipe_pkg::dword_t   rs1_i
   , input  mem_pipe_pkg::dword_t   imm_i
   , input  mem_pipe_pkg::dword_t   rs2_i
   , input  mem_pipe_pkg::reg_idx_t rd_i
   , input  logic                   early_i

   , output logic                   early_v_o
   , output mem_pipe_pkg::dword_t   early_data_o
   , output logic                   final_v_o
   , output mem_pipe_pkg::dword_t   final_data_o
   , output mem_pipe_pkg::reg_idx_t rd_o

   , output logic                   load_misaligned_o
   , output logic                   store_misaligned_o
   , output logic                   load_access_fault_o
   , output logic                   store_access_fault_o
   );

  logic [`MEM_NUM_BANKS-1:0]             bank_en;
  logic                                  bank_we;
  mem_pipe_pkg::bank_idx_t               bank_idx;
  mem_pipe_pkg::dword_t                  bank_wdata;
  mem_pipe_pkg::bmask_t                  bank_wmask;
  logic [`MEM_NUM_BANKS*`MEM_DATA_W-1:0] bank_rdata;

  logic                    ld_v;
  mem_pipe_pkg::mem_op_e   ld_op;
  mem_pipe_pkg::bank_sel_t ld_bank;
  logic [2:0]              ld_byte;
  logic                    ld_early;
  mem_pipe_pkg::reg_idx_t  ld_rd;

  mem_agen u_agen
    (.clk_i(clk_i), .rst_n_i(rst_n_i), .flush_i(flush_i)
     ,.req_v_i(req_v_i), .req_op_i(req_op_i), .rs1_i(rs1_i), .imm_i(imm_i)
     ,.rs2_i(rs2_i), .rd_i(rd_i), .early_i(early_i)
     ,.bank_en_o(bank_en), .bank_we_o(bank_we), .bank_idx_o(bank_idx)
     ,.bank_wdata_o(bank_wdata), .bank_wmask_o(bank_wmask)
     ,.ld_v_o(ld_v), .ld_op_o(ld_op), .ld_bank_o(ld_bank), .ld_byte_o(ld_byte)
     ,.ld_early_o(ld_early), .ld_rd_o(ld_rd)
     ,.load_misaligned_o(load_misaligned_o), .store_misaligned_o(store_misaligned_o)
     ,.load_access_fault_o(load_access_fault_o)
     ,.store_access_fault_o(store_access_fault_o)
     );

  for (genvar g = 0; g < `MEM_NUM_BANKS; g++) begin : g_bank
    mem_bank u_bank
      (.clk_i(clk_i), .en_i(bank_en[g]), .we_i(bank_we), .idx_i(bank_idx)
       ,.wdata_i(bank_wdata), .wmask_i(bank_wmask)
       ,.rdata_o(bank_rdata[g*`MEM_DATA_W +: `MEM_DATA_W])
       );
  end

  mem_align u_align
    (.clk_i(clk_i), .rst_n_i(rst_n_i), .flush_i(flush_i)
     ,.ld_v_i(ld_v), .ld_op_i(ld_op), .ld_bank_i(ld_bank), .ld_byte_i(ld_byte)
     ,.ld_early_i(ld_early), .ld_rd_i(ld_rd), .bank_rdata_i(bank_rdata)
     ,.early_v_o(early_v_o), .early_data_o(early_data_o)
     ,.final_v_o(final_v_o), .final_data_o(final_data_o), .rd_o(rd_o)
     );

endmodule

//--- bench/mem_pipe_chk.sv
// ====================
// Assertions bound into the pipeline top, timing and exclusivity
// ====================
`timescale 1ns/1ps
`include "mem_pipe_config.svh"

module mem_pipe_chk
  (input  logic                      clk_i
   , input  logic                    rst_n_i
   , input  logic [`MEM_NUM_BANKS-1:0] bank_en_i
   , input  logic                    early_v_i
   , input  logic                    final_v_i
   , input  logic [3:0]              exc_i
   );

  // One bank per request, none for a faulting one
  a_bank_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(bank_en_i) && !((|bank_en_i) && (|exc_i)))
    else $error("bank enables not one-hot or raised by a faulting request");

  // An early result never shows again on the final port
  a_early_final: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    early_v_i |=> !final_v_i)
    else $error("request returned on both ports");

  // First clocked cycle after release stays quiet
  a_reset_quiet: assert property (@(posedge clk_i)
    $rose(rst_n_i) |=> !(early_v_i || final_v_i || (|exc_i)))
    else $error("output raised right after reset release");

endmodule

bind mem_pipe_top mem_pipe_chk chk_i
  (.clk_i(clk_i), .rst_n_i(rst_n_i), .bank_en_i(bank_en)
   ,.early_v_i(early_v_o), .final_v_i(final_v_o)
   ,.exc_i({load_misaligned_o, store_misaligned_o, load_access_fault_o,
            store_access_fault_o})
   );

//--- bench/mem_pipe_tb.sv
// ====================
// Testbench for the memory pipeline, runs the request list from the input file
// and checks results, rd, arrival cycle and exception flags
// ====================
`timescale 1ns/1ps
`include "mem_pipe_config.svh"

module mem_pipe_tb;

  // Latencies in negedge counts after the edge that drives the request
  localparam int exc_lat_lp   = 2;
  localparam int early_lat_lp = 4;
  localparam int final_lat_lp = 5;

  // Highest byte address bit of the data memory
  localparam int addr_top_lp  = $clog2(`MEM_BYTES) - 1;

  logic clk_i;
  logic rst_n_i;
  logic flush_i;
  logic req_v_i;
  mem_pipe_pkg::mem_op_e req_op_i;
  logic [63:0] rs1_i;
  logic [63:0] imm_i;
  logic [63:0] rs2_i;
  logic [4:0] rd_i;
  logic early_i;
  logic early_v_o;
  logic [63:0] early_data_o;
  logic final_v_o;
  logic [63:0] final_data_o;
  logic [4:0] rd_o;
  logic load_misaligned_o;
  logic store_misaligned_o;
  logic load_access_fault_o;
  logic store_access_fault_o;

  logic [63:0] ref_mem [`MEM_BYTES/8];
  logic [31:0] lcg_state;
  int ncount;

  // Loads swept over every legal offset of doubleword 0
  string sweep_ops [7] = '{"lb", "lbu", "lh", "lhu", "lw", "lwu", "ld"};

  // Expected results in issue order
  string exp_name [$];
  logic [63:0] exp_data [$];
  logic [4:0] exp_rd [$];
  logic exp_early [$];
  int exp_due [$];
  // Expected exceptions, {lm, sm, lf, sf}
  string exc_name [$];
  logic [3:0] exc_code [$];
  int exc_due [$];

  mem_pipe_top dut_i (.*);

  always #50 clk_i = ~clk_i;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "mismatch");
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic mem_pipe_pkg::mem_op_e op_from_name(input string s);
    case (s)
      "lb":    return mem_pipe_pkg::e_lb;
      "lh":    return mem_pipe_pkg::e_lh;
      "lw":    return mem_pipe_pkg::e_lw;
      "lbu":   return mem_pipe_pkg::e_lbu;
      "lhu":   return mem_pipe_pkg::e_lhu;
      "lwu":   return mem_pipe_pkg::e_lwu;
      "sb":    return mem_pipe_pkg::e_sb;
      "sh":    return mem_pipe_pkg::e_sh;
      "sw":    return mem_pipe_pkg::e_sw;
      "sd":    return mem_pipe_pkg::e_sd;
      default: return mem_pipe_pkg::e_ld;
    endcase
  endfunction

  // Access size in bytes
  function automatic int access_bytes(input string op);
    case (op)
      "lb", "lbu", "sb": return 1;
      "lh", "lhu", "sh": return 2;
      "lw", "lwu", "sw": return 4;
      default:           return 8;
    endcase
  endfunction

  // Reference load, natural byte order inside the doubleword
  function automatic logic [63:0] model_load(input string op, input logic [63:0] a);
    logic [63:0] sh;
    sh = ref_mem[a[addr_top_lp:3]] >> (8 * a[2:0]);
    case (op)
      "lb":    return {{56{sh[7]}}, sh[7:0]};
      "lh":    return {{48{sh[15]}}, sh[15:0]};
      "lw":    return {{32{sh[31]}}, sh[31:0]};
      "lbu":   return {56'd0, sh[7:0]};
      "lhu":   return {48'd0, sh[15:0]};
      "lwu":   return {32'd0, sh[31:0]};
      default: return sh;
    endcase
  endfunction

  task automatic model_store(input string op, input logic [63:0] a, input logic [63:0] d);
    int n;
    n = access_bytes(op);
    for (int b = 0; b < n; b++) begin
      ref_mem[a[addr_top_lp:3]][(a[2:0] + b) * 8 +: 8] = d[b*8 +: 8];
    end
  endtask

  task automatic drive_req(input string op, input logic [63:0] rs1, input logic [63:0] imm,
                           input logic [63:0] rs2, input logic [4:0] rd, input logic early,
                           output int issue);
    @(posedge clk_i);
    issue    = ncount;
    req_v_i  <= 1'b1;
    req_op_i <= op_from_name(op);
    rs1_i    <= rs1;
    imm_i    <= imm;
    rs2_i    <= rs2;
    rd_i     <= rd;
    early_i  <= early;
  endtask

  task automatic expect_load(input string name, input string op, input logic [63:0] a,
                             input logic [4:0] rd, input logic early, input int issue);
    exp_name.push_back(name);
    exp_data.push_back(model_load(op, a));
    exp_rd.push_back(rd);
    exp_early.push_back(early);
    exp_due.push_back(issue + (early ? early_lat_lp : final_lat_lp));
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk_i);
      req_v_i <= 1'b0;
    end
  endtask

  task automatic check_port(input logic is_early, input logic [63:0] data);
    if (exp_name.size() == 0) begin
      abort_run("A load result appeared that no request should have produced");
    end
    check_value({exp_name[0], " port"}, exp_early[0], is_early);
    check_value({exp_name[0], " cycle"}, exp_due[0], ncount);
    check_value({exp_name[0], " data"}, exp_data[0], data);
    check_value({exp_name[0], " rd"}, exp_rd[0], rd_o);
    void'(exp_name.pop_front());
    void'(exp_data.pop_front());
    void'(exp_rd.pop_front());
    void'(exp_early.pop_front());
    void'(exp_due.pop_front());
  endtask

  // Outputs sampled at the falling edge, half a cycle after they change
  always @(negedge clk_i) begin
    logic [3:0] act_exc;
    ncount++;
    if (rst_n_i) begin
      act_exc = {load_misaligned_o, store_misaligned_o, load_access_fault_o,
                 store_access_fault_o};
      if (exc_due.size() > 0 && exc_due[0] == ncount) begin
        check_value({exc_name[0], " exception"}, exc_code[0], act_exc);
        void'(exc_name.pop_front());
        void'(exc_code.pop_front());
        void'(exc_due.pop_front());
      end else begin
        check_value("idle exception flags", 4'd0, act_exc);
      end
      // Final port holds the older request
      if (final_v_o) check_port(1'b0, final_data_o);
      if (early_v_o) check_port(1'b1, early_data_o);
      if (exp_due.size() > 0 && ncount > exp_due[0]) begin
        abort_run({"The result of ", exp_name[0], " did not arrive in time"});
      end
    end
  end

  initial begin
    int fd;
    int issue;
    int waited;
    string line;
    string name;
    string op;
    string kind;
    logic [63:0] rs1;
    logic [63:0] imm;
    logic [63:0] rs2;
    logic [63:0] expv;
    logic [63:0] val;
    int rd;
    int early;
    int idle;
    clk_i     = 1'b0;
    rst_n_i   = 1'b0;
    flush_i   = 1'b0;
    req_v_i   = 1'b0;
    req_op_i  = mem_pipe_pkg::e_ld;
    rs1_i     = '0;
    imm_i     = '0;
    rs2_i     = '0;
    rd_i      = '0;
    early_i   = 1'b0;
    ncount    = 0;
    lcg_state = 32'hda268501;
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;
    repeat (2) @(posedge clk_i);

    // Background pattern over the whole memory
    for (int i = 0; i < `MEM_BYTES / 8; i++) begin
      val = {lcg_next(), lcg_next()};
      ref_mem[i] = val;
      drive_req("sd", 64'(i * 8), 64'd0, val, 5'd0, 1'b0, issue);
    end
    idle_cycles(3);

    fd = $fopen("bench/mem_pipe_input.txt", "r");
    if (fd == 0) abort_run("Could not open the input file bench/mem_pipe_input.txt");
    while ($fgets(line, fd) > 0) begin
      if (line.len() < 2 || line.substr(0, 0) == "#") continue;
      if ($sscanf(line, "%s %s %h %h %h %d %d %s %h %d", name, op, rs1, imm, rs2, rd,
                  early, kind, expv, idle) != 10) begin
        abort_run({"Malformed line in the input file: ", line});
      end
      if (kind == "F") begin
        @(posedge clk_i);
        req_v_i <= 1'b0;
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
      end else begin
        drive_req(op, rs1, imm, rs2, 5'(rd), 1'(early), issue);
        case (kind)
          "N": model_store(op, rs1 + imm, rs2);
          "R", "M": begin
            if (kind == "R") check_value({name, " model"}, expv, model_load(op, rs1 + imm));
            expect_load(name, op, rs1 + imm, 5'(rd), 1'(early), issue);
          end
          "LM", "SM", "LF", "SF": begin
            exc_name.push_back(name);
            exc_code.push_back(kind == "LM" ? 4'b1000 : kind == "SM" ? 4'b0100 :
                               kind == "LF" ? 4'b0010 : 4'b0001);
            exc_due.push_back(issue + exc_lat_lp);
          end
          default: ;
        endcase
      end
      idle_cycles(idle);
    end
    $fclose(fd);

    // Every legal offset of doubleword 0, also where a wrapped store would land
    for (int k = 0; k < 7; k++) begin
      for (int off = 0; off < 8; off += access_bytes(sweep_ops[k])) begin
        drive_req(sweep_ops[k], 64'(off), 64'd0, 64'd0, 5'(off + 1), 1'b0, issue);
        expect_load($sformatf("sweep_%s_%0d", sweep_ops[k], off), sweep_ops[k], 64'(off),
                    5'(off + 1), 1'b0, issue);
      end
    end
    idle_cycles(1);

    waited = 0;
    while ((exp_name.size() > 0 || exc_name.size() > 0) && waited < 50) begin
      @(posedge clk_i);
      waited++;
    end
    if (exp_name.size() == 0 && exc_name.size() == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("Timed out waiting for the last results");
      $display("TEST FAIL");
      $fatal(1, "timeout");
    end
  end

endmodule

//--- bench/mem_pipe_input.txt
# name op rs1 imm rs2 rd early kind expected idle (numbers hex except rd, early, idle)
# kind: N store, R load vs value, M load vs background, K killed, LM SM LF SF fault, F flush
sd_a sd 100 0 1122334455667788 0 0 N 0 0
ld_a_final ld 100 0 0 1 0 R 1122334455667788 5
ld_a_early ld f0 10 0 2 1 R 1122334455667788 5
sb_a sb 103 0 ff 0 0 N 0 0
sh_a sh 106 0 abcd 0 0 N 0 0
ld_part ld 100 0 0 3 0 R abcd3344ff667788 5
sd_b sd 108 0 f0e0d0c0b0a09080 0 0 N 0 0
lb_b0 lb 108 0 0 4 0 R ffffffffffffff80 0
lbu_b7 lbu 10f 0 0 5 0 R f0 0
lh_b2 lh 10a 0 0 6 0 R ffffffffffffb0a0 0
lhu_b6 lhu 10e 0 0 7 0 R f0e0 0
lw_b4 lw 10c 0 0 8 0 R fffffffff0e0d0c0 0
lwu_b0 lwu 108 0 0 9 0 R b0a09080 5
sw_c sw 110 4 7f017f01 0 0 N 0 0
lw_c lw 114 0 0 10 0 R 7f017f01 0
lb_c lb 117 0 0 11 0 R 7f 0
lh_c lh 112 4 0 12 0 R 7f01 5
bg_lb1 lb 201 0 0 13 1 M 0 0
bg_lbu3 lbu 20b 0 0 14 1 M 0 0
bg_lh2 lh 212 0 0 15 1 M 0 5
bg_lhu4 lhu 21c 0 0 16 0 M 0 0
bg_lw4 lw 224 0 0 17 0 M 0 0
bg_lb5 lb 22d 0 0 18 0 M 0 5
lh_mis lh 101 0 0 19 0 LM 0 1
ld_mis ld 104 0 0 19 0 LM 0 1
sw_mis sw 102 0 deadbeef 0 0 SM 0 1
sd_mis sd 101 0 deadbeefdeadbeef 0 0 SM 0 1
ld_oob ld 800 0 0 19 0 LF 0 1
sd_oob sd 7f8 8 1 0 0 SF 0 1
lw_wrap lw ffffffffffffff00 0 0 19 0 LF 0 1
ld_keep ld 100 0 0 20 0 R abcd3344ff667788 5
b2b_0 ld 100 0 0 21 0 R abcd3344ff667788 0
b2b_1 lwu 108 0 0 22 0 R b0a09080 0
b2b_2 lw 114 0 0 23 0 R 7f017f01 5
fl_0 ld 200 0 0 24 0 K 0 0
fl_1 ld 208 0 0 25 1 K 0 0
flush ld 0 0 0 0 0 F 0 1
post_flush ld 108 0 0 26 1 R f0e0d0c0b0a09080 5

//--- project.f
+incdir+hdl
hdl/mem_pipe_pkg.sv
hdl/mem_agen.sv
hdl/mem_bank.sv
hdl/mem_align.sv
hdl/mem_pipe_top.sv
bench/mem_pipe_chk.sv
bench/mem_pipe_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the memory pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module mem_pipe_tb -f project.f -o sim_mem_pipe

./obj_dir/sim_mem_pipe > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
  exit 0
else
  echo "simulation did not pass"
  exit 1
fi
